// ==== l1d_cache.f ====
hw/l1d_pkg.sv
hw/d0_scheduler.sv
hw/d0_req_encoder.sv
hw/d0_stage.sv
hw/d1_stage.sv
hw/l1d_cache.sv
bench/tb_clock_gen.sv
bench/l1d_cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the cache with its testbench in Verilator, runs it and searches the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module l1d_cache_tb -f l1d_cache.f \
  -o l1d_cache_sim > build.log 2>&1 &&
  ./obj_dir/l1d_cache_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "Simulation passed" && exit 0 ||
  { echo "Simulation failed"; exit 1; }

// ==== bench/l1d_cache_tb.sv ====
`timescale 1ns/1ns

module l1d_cache_tb;

  import l1d_pkg::*;

  localparam int unsigned IDX_W    = 4;
  localparam int unsigned SETS     = 1 << IDX_W;
  localparam int unsigned NUM_REQS = 400;
  localparam int unsigned TIMEOUT  = NUM_REQS * 20 + 100;
  // Low six bits are zero, so 64 doublewords follow this base
  localparam addr_t       BASE     = 16'h2c40;

  // One accepted LSQ access waiting for its response
  typedef struct packed {
    logic        store;
    logic        hit;
    dword_t      exp_data;
    logic [31:0] cycle;
  } pend_t;

  // L2 request that the shadow cache predicts and the cycle it is due in
  typedef struct packed {
    l2_req_t     req;
    logic [31:0] cycle;
  } l2_exp_t;

  logic    clk;
  logic    rst_n;
  logic    lsq_valid;
  lsq_req_t lsq_req;
  logic    lsq_ready;
  logic    resp_valid;
  dword_t  resp_data;
  logic    l2_req_valid;
  l2_req_t l2_req;
  logic    l2_ans_valid;
  l2_ans_t l2_ans;

  // Golden memory as the LSQ sees it and the L2 backing memory
  dword_t  golden  [64];
  dword_t  backing [64];
  // Shadow of the cache state per set
  logic    sh_valid [SETS];
  logic    sh_dirty [SETS];
  addr_t   sh_tag   [SETS];

  pend_t   pend_q   [$];
  l2_exp_t l2_exp_q [$];

  integer      seed;
  int unsigned cycle_cnt;
  int unsigned sweep_cnt;
  int unsigned answered;
  int unsigned fill_due;
  logic        fill_pend;
  addr_t       fill_addr;

  tb_clock_gen u_tb_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  l1d_cache #(
    .IDX_W (IDX_W)
  ) u_l1d_cache (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .lsq_valid_i      (lsq_valid),
    .lsq_req_i        (lsq_req),
    .lsq_ready_o      (lsq_ready),
    .lsq_resp_valid_o (resp_valid),
    .lsq_resp_data_o  (resp_data),
    .l2_req_valid_o   (l2_req_valid),
    .l2_req_o         (l2_req),
    .l2_ans_valid_i   (l2_ans_valid),
    .l2_ans_i         (l2_ans)
  );

  // Initial memory content depends on every address bit
  function automatic dword_t mem_pattern(input addr_t a);
    mem_pattern = {a, ~a, a ^ 16'h5ac3, a + 16'h1d07};
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // New random access within the 64 doublewords that is held until ready
  task automatic drive_request();
    logic [31:0] r;
    lsq_req_t    req;
    r         = $random(seed);
    req.store = r[0];
    req.addr  = BASE | addr_t'(r[6:1]);
    req.data  = {$random(seed), $random(seed)};
    lsq_valid <= 1'b1;
    lsq_req   <= req;
  endtask

  // Predicts hit or miss from the shadow and updates it as the cache will
  task automatic accept_request();
    pend_t            p;
    l2_exp_t          e;
    logic [IDX_W-1:0] idx;
    idx        = lsq_req.addr[IDX_W-1:0];
    p.store    = lsq_req.store;
    p.hit      = sh_valid[idx] && (sh_tag[idx] == lsq_req.addr);
    p.exp_data = golden[lsq_req.addr[5:0]];
    p.cycle    = cycle_cnt;
    if (pend_q.size() != 0) begin
      report_failure("LSQ request accepted while an earlier one had no response yet");
    end else begin
      if (!p.hit) begin
        e.req.addr    = lsq_req.addr;
        e.req.wb      = sh_valid[idx] && sh_dirty[idx];
        e.req.wb_addr = sh_tag[idx];
        e.req.wb_data = golden[sh_tag[idx][5:0]];
        e.cycle       = cycle_cnt + 2;
        l2_exp_q.push_back(e);
        sh_valid[idx] = 1'b1;
        sh_tag[idx]   = lsq_req.addr;
        sh_dirty[idx] = lsq_req.store;
      end else if (lsq_req.store) begin
        sh_dirty[idx] = 1'b1;
      end
      if (lsq_req.store) begin
        golden[lsq_req.addr[5:0]] = lsq_req.data;
      end
      pend_q.push_back(p);
    end
  endtask

  task automatic take_response();
    pend_t p;
    if (pend_q.size() == 0) begin
      report_failure("LSQ response arrived with no accepted request");
    end else begin
      p        = pend_q.pop_front();
      answered = answered + 1;
      if (!p.store) begin
        check_value("lsq_resp_data_o", resp_data, p.exp_data);
      end
      if (p.hit) begin
        check_value("lsq_resp_valid_o latency", 64'(cycle_cnt - p.cycle), 64'd2);
      end else if (l2_exp_q.size() != 0) begin
        report_failure("Miss was answered before its L2 request went out");
      end
    end
  endtask

  // Checks the miss request, takes the writeback and schedules the fill
  task automatic take_l2_request();
    l2_exp_t e;
    if (l2_exp_q.size() == 0) begin
      report_failure("L2 request raised although the shadow cache predicts a hit");
    end else begin
      e = l2_exp_q.pop_front();
      check_value("l2_req_valid_o cycle", 64'(cycle_cnt), 64'(e.cycle));
      check_value("l2_req_o.addr", 64'(l2_req.addr), 64'(e.req.addr));
      check_value("l2_req_o.wb", 64'(l2_req.wb), 64'(e.req.wb));
      if (e.req.wb) begin
        check_value("l2_req_o.wb_addr", 64'(l2_req.wb_addr), 64'(e.req.wb_addr));
        check_value("l2_req_o.wb_data", l2_req.wb_data, e.req.wb_data);
        backing[l2_req.wb_addr[5:0]] = l2_req.wb_data;
      end
      fill_pend = 1'b1;
      fill_addr = l2_req.addr;
      fill_due  = cycle_cnt + 5;
    end
  endtask

  // Outputs are sampled mid-cycle and the response is taken before a new grant
  always @(negedge clk) begin
    if (!rst_n || (sweep_cnt < SETS)) begin
      check_value("lsq_ready_o", 64'(lsq_ready), 64'h0);
      check_value("lsq_resp_valid_o", 64'(resp_valid), 64'h0);
      check_value("l2_req_valid_o", 64'(l2_req_valid), 64'h0);
      if (rst_n) begin
        sweep_cnt = sweep_cnt + 1;
      end
    end
    if (resp_valid === 1'b1) begin
      take_response();
    end
    if (l2_req_valid === 1'b1) begin
      take_l2_request();
    end
    if (lsq_ready === 1'b1) begin
      accept_request();
    end
  end

  // Cycle count, run limit and the L2 fill five cycles after the request
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      report_failure($sformatf("Timeout, run still busy after %0d cycles", cycle_cnt));
    end else if (fill_pend && (cycle_cnt == fill_due)) begin
      l2_ans_valid <= 1'b1;
      l2_ans       <= '{addr: fill_addr, data: backing[fill_addr[5:0]]};
      fill_pend     = 1'b0;
    end else begin
      l2_ans_valid <= 1'b0;
    end
  end

  initial begin
    logic [31:0] r;
    seed         = 28;
    cycle_cnt    = 0;
    sweep_cnt    = 0;
    answered     = 0;
    fill_due     = 0;
    fill_pend    = 1'b0;
    fill_addr    = BASE;
    lsq_valid    = 1'b0;
    lsq_req      = '0;
    l2_ans_valid = 1'b0;
    l2_ans       = '0;
    for (int i = 0; i < 64; i++) begin
      golden[i]  = mem_pattern(BASE | addr_t'(i));
      backing[i] = mem_pattern(BASE | addr_t'(i));
    end
    for (int i = 0; i < SETS; i++) begin
      sh_valid[i] = 1'b0;
      sh_dirty[i] = 1'b0;
      sh_tag[i]   = BASE;
    end
    // The first request already waits through reset and the sweep
    for (int n = 0; n < NUM_REQS; n++) begin
      r = $random(seed);
      repeat (r[1:0]) @(posedge clk);
      @(posedge clk);
      drive_request();
      @(negedge clk);
      while (lsq_ready !== 1'b1) begin
        @(negedge clk);
      end
      @(posedge clk);
      lsq_valid <= 1'b0;
    end
    while (answered < NUM_REQS) begin
      @(posedge clk);
    end
    @(posedge clk);
    if ((pend_q.size() == 0) && (l2_exp_q.size() == 0) && !fill_pend) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      report_failure("Requests or L2 traffic still outstanding at the end of the run");
    end
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int unsigned HALF_PERIOD = 10,
  parameter int unsigned RST_CYCLES  = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock with a 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Reset is held low for the first cycles and released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== hw/l1d_cache.sv ====
`timescale 1ns/1ns

module l1d_cache #(
  parameter int unsigned IDX_W = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Load/store queue side
  input  logic              lsq_valid_i,
  input  l1d_pkg::lsq_req_t lsq_req_i,
  output logic              lsq_ready_o,
  output logic              lsq_resp_valid_o,
  output l1d_pkg::dword_t   lsq_resp_data_o,
  // L2 side
  output logic              l2_req_valid_o,
  output l1d_pkg::l2_req_t  l2_req_o,
  input  logic              l2_ans_valid_i,
  input  l1d_pkg::l2_ans_t  l2_ans_i
);

  import l1d_pkg::*;

  d0_winner_e       winner;
  logic [IDX_W-1:0] rst_idx;
  d1_req_t          d1_req;
  logic             d1_busy;
  d0_req_type_e     d0_req_type;
  d0_d1_req_type_e  d1_next_req_type;
  d0_d1_t           d0_d1;
  lsq_d0_req_type_e lsq_req_type;

  // The LSQ sends a store flag, the encoder wants the request kind
  assign lsq_req_type = lsq_req_i.store ? Store : Load;

  d0_scheduler #(
    .IDX_W (IDX_W)
  ) u_d0_scheduler (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .lsq_valid_i    (lsq_valid_i),
    .l2_ans_valid_i (l2_ans_valid_i),
    .d1_req_type_i  (d1_req.req_type),
    .d1_busy_i      (d1_busy),
    .winner_o       (winner),
    .rst_idx_o      (rst_idx),
    .lsq_ready_o    (lsq_ready_o)
  );

  d0_req_encoder u_d0_req_encoder (
    .winner_i           (winner),
    .d1_req_type_i      (d1_req.req_type),
    .lsq_req_type_i     (lsq_req_type),
    .d0_req_type_o      (d0_req_type),
    .d1_next_req_type_o (d1_next_req_type)
  );

  d0_stage #(
    .IDX_W (IDX_W)
  ) u_d0_stage (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .d0_req_type_i      (d0_req_type),
    .d1_next_req_type_i (d1_next_req_type),
    .rst_idx_i          (rst_idx),
    .lsq_req_i          (lsq_req_i),
    .d1_req_i           (d1_req),
    .l2_ans_i           (l2_ans_i),
    .d0_d1_o            (d0_d1)
  );

  d1_stage u_d1_stage (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .d0_d1_i          (d0_d1),
    .d1_req_o         (d1_req),
    .d1_busy_o        (d1_busy),
    .lsq_resp_valid_o (lsq_resp_valid_o),
    .lsq_resp_data_o  (lsq_resp_data_o),
    .l2_req_valid_o   (l2_req_valid_o),
    .l2_req_o         (l2_req_o)
  );

endmodule

// ==== hw/d1_stage.sv ====
`timescale 1ns/1ns

module d1_stage (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  l1d_pkg::d0_d1_t  d0_d1_i,
  output l1d_pkg::d1_req_t d1_req_o,
  output logic             d1_busy_o,
  output logic             lsq_resp_valid_o,
  output l1d_pkg::dword_t  lsq_resp_data_o,
  output logic             l2_req_valid_o,
  output l1d_pkg::l2_req_t l2_req_o
);

  import l1d_pkg::*;

  logic            is_lsq_op;
  logic            is_store_op;
  logic            is_fill;
  logic            hit;
  logic            miss;

  logic            resp_valid_q;
  dword_t          resp_data_q;
  logic            l2_req_valid_q;
  l2_req_t         l2_req_q;

  // Request towards d0, the address and data double as the parked access
  d1_d0_req_type_e req_type_q;
  addr_t           req_addr_q;
  dword_t          req_data_q;
  logic            parked_q;
  logic            park_store_q;

  // A load or a store from the LSQ or from a replay sits in d1 this cycle
  assign is_lsq_op   = (d0_d1_i.req_type == d0_d1_Load) ||
                       (d0_d1_i.req_type == d0_d1_Store);
  assign is_store_op = (d0_d1_i.req_type == d0_d1_Store);
  assign is_fill     = (d0_d1_i.req_type == d0_d1_LineFill);

  // The whole doubleword address is the tag, so a hit is a plain compare
  assign hit  = d0_d1_i.line_valid && (d0_d1_i.line_addr == d0_d1_i.addr);
  assign miss = is_lsq_op && !hit;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_q   <= 1'b0;
      l2_req_valid_q <= 1'b0;
      req_type_q     <= D1Idle;
      parked_q       <= 1'b0;
    end else begin
      // Both hits answer the LSQ two cycles after the grant
      resp_valid_q   <= is_lsq_op && hit;
      l2_req_valid_q <= miss;
      // D1 outranks the LSQ and L2 only fills our own parked miss,
      // so a raised request is granted in the very cycle it is shown
      req_type_q <= D1Idle;
      if (is_store_op && hit) begin
        req_type_q <= WriteStore;
      end
      if (miss) begin
        parked_q <= 1'b1;
      end else if (parked_q && is_fill) begin
        // The line is in place now, run the access again
        parked_q   <= 1'b0;
        req_type_q <= park_store_q ? StoreReplay : LoadReplay;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (is_lsq_op && hit) begin
      resp_data_q <= d0_d1_i.line_data;
    end
    // Keep the access around, it feeds WriteStore or the later replay
    if (is_lsq_op) begin
      req_addr_q   <= d0_d1_i.addr;
      req_data_q   <= d0_d1_i.data;
      park_store_q <= is_store_op;
    end
    if (miss) begin
      l2_req_q.addr    <= d0_d1_i.addr;
      // Only a valid and dirty victim has to go back to L2
      l2_req_q.wb      <= d0_d1_i.line_valid && d0_d1_i.line_dirty;
      l2_req_q.wb_addr <= d0_d1_i.line_addr;
      l2_req_q.wb_data <= d0_d1_i.line_data;
    end
  end

  assign d1_req_o = '{
    req_type: req_type_q,
    addr:     req_addr_q,
    data:     req_data_q
  };

  // Busy covers the access itself, a raised request and a parked miss
  assign d1_busy_o = is_lsq_op || (req_type_q != D1Idle) || parked_q;

  assign lsq_resp_valid_o = resp_valid_q;
  assign lsq_resp_data_o  = resp_data_q;

  // Single-cycle pulse, one request per miss
  assign l2_req_valid_o = l2_req_valid_q;
  assign l2_req_o       = l2_req_q;

endmodule

// ==== hw/d0_stage.sv ====
`timescale 1ns/1ns

module d0_stage #(
  parameter int unsigned IDX_W = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  l1d_pkg::d0_req_type_e    d0_req_type_i,
  input  l1d_pkg::d0_d1_req_type_e d1_next_req_type_i,
  input  logic [IDX_W-1:0]         rst_idx_i,
  input  l1d_pkg::lsq_req_t        lsq_req_i,
  input  l1d_pkg::d1_req_t         d1_req_i,
  input  l1d_pkg::l2_ans_t         l2_ans_i,
  output l1d_pkg::d0_d1_t          d0_d1_o
);

  import l1d_pkg::*;

  localparam int unsigned SETS = 1 << IDX_W;

  // Cache arrays hold one doubleword line per set
  logic   valid_q [SETS];
  logic   dirty_q [SETS];
  addr_t  tag_q   [SETS];
  dword_t data_q  [SETS];

  addr_t            acc_addr;
  dword_t           acc_data;
  logic [IDX_W-1:0] set_idx;

  d0_d1_req_type_e  op_q;
  addr_t            addr_q;
  dword_t           wdata_q;
  logic             line_valid_q;
  logic             line_dirty_q;
  addr_t            line_addr_q;
  dword_t           line_data_q;

  // Address and data of the access follow the requester of the operation
  always_comb begin
    acc_addr = lsq_req_i.addr;
    acc_data = lsq_req_i.data;
    case (d0_req_type_i)
      d0_ReadD1, d0_WriteStoreD1: begin
        acc_addr = d1_req_i.addr;
        acc_data = d1_req_i.data;
      end
      d0_WriteL2Line: begin
        acc_addr = l2_ans_i.addr;
        acc_data = l2_ans_i.data;
      end
      default: begin
        acc_addr = lsq_req_i.addr;
        acc_data = lsq_req_i.data;
      end
    endcase
  end

  // The reset sweep indexes the sets directly and every other operation uses the address
  assign set_idx = (d0_req_type_i == d0_ResetLines) ? rst_idx_i : acc_addr[IDX_W-1:0];

  // Array writes land at the end of the grant cycle
  always_ff @(posedge clk_i) begin
    case (d0_req_type_i)
      d0_WriteL2Line: begin
        // A fresh line from L2 is valid and clean
        valid_q[set_idx] <= 1'b1;
        dirty_q[set_idx] <= 1'b0;
        tag_q[set_idx]   <= acc_addr;
        data_q[set_idx]  <= acc_data;
      end
      d0_WriteStoreD1: begin
        // The tag already matches here because d1 only asks after a hit
        data_q[set_idx]  <= acc_data;
        dirty_q[set_idx] <= 1'b1;
      end
      d0_ResetLines: begin
        valid_q[set_idx] <= 1'b0;
      end
      default: begin
        // Reads leave the arrays as they are
      end
    endcase
  end

  // d1 sees no operation until the first grant after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      op_q <= d0_d1_Idle;
    end else begin
      op_q <= d1_next_req_type_i;
    end
  end

  // The line is captured as read before any write of this cycle
  always_ff @(posedge clk_i) begin
    addr_q       <= acc_addr;
    wdata_q      <= acc_data;
    line_valid_q <= valid_q[set_idx];
    line_dirty_q <= dirty_q[set_idx];
    line_addr_q  <= tag_q[set_idx];
    line_data_q  <= data_q[set_idx];
  end

  assign d0_d1_o = '{
    req_type:   op_q,
    addr:       addr_q,
    data:       wdata_q,
    line_valid: line_valid_q,
    line_dirty: line_dirty_q,
    line_addr:  line_addr_q,
    line_data:  line_data_q
  };

endmodule

// ==== hw/d0_req_encoder.sv ====
`timescale 1ns/1ns

module d0_req_encoder (
  // Winner chosen by the scheduler
  input  l1d_pkg::d0_winner_e       winner_i,
  // Kinds of the pending requests
  input  l1d_pkg::d1_d0_req_type_e  d1_req_type_i,
  input  l1d_pkg::lsq_d0_req_type_e lsq_req_type_i,
  // Operation for the arrays in this cycle
  output l1d_pkg::d0_req_type_e     d0_req_type_o,
  // Operation loaded into the d0 to d1 record
  output l1d_pkg::d0_d1_req_type_e  d1_next_req_type_o
);

  import l1d_pkg::*;

  always_comb begin
    // Nothing happens unless a winner asks for it
    d0_req_type_o      = d0_Idle;
    d1_next_req_type_o = d0_d1_Idle;
    case (winner_i)
      LSQ: begin
        // Both kinds read the set in d0, d1 then checks the hit
        d0_req_type_o = d0_ReadLsq;
        if (lsq_req_type_i == Store) begin
          d1_next_req_type_o = d0_d1_Store;
        end else begin
          d1_next_req_type_o = d0_d1_Load;
        end
      end
      L2Cache: begin
        // The fill is written in d0 and d1 learns that the parked miss can go
        d0_req_type_o      = d0_WriteL2Line;
        d1_next_req_type_o = d0_d1_LineFill;
      end
      D1: begin
        case (d1_req_type_i)
          LoadReplay: begin
            // Replayed load reads with the d1 address and checks again
            d0_req_type_o      = d0_ReadD1;
            d1_next_req_type_o = d0_d1_Load;
          end
          StoreReplay: begin
            // Replayed store reads first, the write follows as WriteStore
            d0_req_type_o      = d0_ReadD1;
            d1_next_req_type_o = d0_d1_Store;
          end
          WriteStore: begin
            // Store hit data goes into the line, d1 has nothing left to do
            d0_req_type_o      = d0_WriteStoreD1;
            d1_next_req_type_o = d0_d1_Idle;
          end
          default: begin
            d0_req_type_o      = d0_Idle;
            d1_next_req_type_o = d0_d1_Idle;
          end
        endcase
      end
      RstBlock: begin
        // Invalidate the set under the sweep index
        d0_req_type_o      = d0_ResetLines;
        d1_next_req_type_o = d0_d1_Idle;
      end
      default: begin
        d0_req_type_o      = d0_Idle;
        d1_next_req_type_o = d0_d1_Idle;
      end
    endcase
  end

endmodule

// ==== hw/d0_scheduler.sv ====
`timescale 1ns/1ns

module d0_scheduler #(
  parameter int unsigned IDX_W = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     lsq_valid_i,
  input  logic                     l2_ans_valid_i,
  input  l1d_pkg::d1_d0_req_type_e d1_req_type_i,
  input  logic                     d1_busy_i,
  output l1d_pkg::d0_winner_e      winner_o,
  output logic [IDX_W-1:0]         rst_idx_o,
  output logic                     lsq_ready_o
);

  import l1d_pkg::*;

  sched_state_e     state_q;
  sched_state_e     state_d;
  logic [IDX_W-1:0] rst_cnt_q;
  logic             prev_grant_q;
  logic             lsq_ok;

  // The sweep leaves the reset state once the last set has been cleared
  always_comb begin
    state_d = state_q;
    if ((state_q == SchedReset) && (&rst_cnt_q)) begin
      state_d = SchedRun;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= SchedReset;
      rst_cnt_q    <= '0;
      prev_grant_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // One set is invalidated per cycle, the counter wraps back to zero
      if (state_q == SchedReset) begin
        rst_cnt_q <= rst_cnt_q + 1'b1;
      end
      // LSQ and D1 grants both put a new access into d1 next cycle
      prev_grant_q <= (winner_o == LSQ) || (winner_o == D1);
    end
  end

  // The LSQ waits until d1 is free and the previous grant has left d0
  assign lsq_ok = !d1_busy_i && !prev_grant_q;

  // Fixed priority with the reset block, then L2, then D1, then the LSQ
  always_comb begin
    winner_o = NoWinner;
    if (state_q == SchedReset) begin
      winner_o = RstBlock;
    end else if (l2_ans_valid_i) begin
      // Fills are never back-pressured, L2 has no way to hold them
      winner_o = L2Cache;
    end else if (d1_req_type_i != D1Idle) begin
      winner_o = D1;
    end else if (lsq_valid_i && lsq_ok) begin
      winner_o = LSQ;
    end
  end

  // Sweep index goes straight to the arrays
  assign rst_idx_o = rst_cnt_q;

  // The LSQ sees its grant as a single-cycle ready pulse
  assign lsq_ready_o = (winner_o == LSQ);

endmodule

// ==== hw/l1d_pkg.sv ====
package l1d_pkg;

  // Doubleword address width, one line holds exactly one doubleword
  localparam int unsigned ADDR_W = 16;

  // Doubleword address, also stored whole as the tag of a line
  typedef logic [ADDR_W-1:0] addr_t;

  // One data doubleword, the unit of every access
  typedef logic [63:0] dword_t;

  // Requester that won the d0 slot in the current cycle
  typedef enum logic [2:0] {
    NoWinner,
    RstBlock,
    L2Cache,
    D1,
    LSQ
  } d0_winner_e;

  // Kind of access coming from the load/store queue
  typedef enum logic {
    Load,
    Store
  } lsq_d0_req_type_e;

  // Kind of request raised by the second stage
  typedef enum logic [1:0] {
    D1Idle,
    LoadReplay,
    StoreReplay,
    WriteStore
  } d1_d0_req_type_e;

  // Operation carried out on the arrays in d0
  typedef enum logic [2:0] {
    d0_Idle,
    d0_ReadLsq,
    d0_ReadD1,
    d0_WriteL2Line,
    d0_WriteStoreD1,
    d0_ResetLines
  } d0_req_type_e;

  // Operation that d1 carries out one cycle after d0
  typedef enum logic [1:0] {
    d0_d1_Idle,
    d0_d1_Load,
    d0_d1_Store,
    d0_d1_LineFill
  } d0_d1_req_type_e;

  // Scheduler FSM, sweeping the sets first and then arbitrating
  typedef enum logic {
    SchedReset,
    SchedRun
  } sched_state_e;

  // Request from the load/store queue
  typedef struct packed {
    logic   store;
    addr_t  addr;
    dword_t data;
  } lsq_req_t;

  // Request from d1 back into d0
  typedef struct packed {
    d1_d0_req_type_e req_type;
    addr_t           addr;
    dword_t          data;
  } d1_req_t;

  // Pipeline record from d0 to d1, with the line as it was read in d0
  typedef struct packed {
    d0_d1_req_type_e req_type;
    addr_t           addr;
    dword_t          data;
    logic            line_valid;
    logic            line_dirty;
    addr_t           line_addr;
    dword_t          line_data;
  } d0_d1_t;

  // Miss request to L2, with the dirty victim attached when there is one
  typedef struct packed {
    addr_t  addr;
    logic   wb;
    addr_t  wb_addr;
    dword_t wb_data;
  } l2_req_t;

  // Line fill returned by L2
  typedef struct packed {
    addr_t  addr;
    dword_t data;
  } l2_ans_t;

endpackage
